// ==== cache_arbiter.sv ====
module cache_arbiter
    (
        input  logic                clk,
        input  logic                rst,

        input  mem_port_pkg::addr_t i_imem_addr,
        input  logic                i_imem_read,
        output mem_port_pkg::line_t o_imem_rdata,
        output logic                o_imem_resp,

        input  mem_port_pkg::addr_t i_dmem_addr,
        input  logic                i_dmem_read,
        input  logic                i_dmem_write,
        input  mem_port_pkg::line_t i_dmem_wdata,
        output mem_port_pkg::line_t o_dmem_rdata,
        output logic                o_dmem_resp,

        input  logic                i_bmem_ready,
        output mem_port_pkg::addr_t o_bmem_addr,
        output logic                o_bmem_read,

        output logic                o_ser_start,
        output mem_port_pkg::line_t o_ser_line,
        input  logic                i_ser_done,

        input  mem_port_pkg::line_t i_line,
        input  logic                i_line_valid
    );

    typedef enum logic [2:0]
    {
        idle,
        read_issue,
        read_wait,
        write_issue,
        write_wait
    } arb_state_t;

    arb_state_t state;
    arb_state_t state_next;

    logic grant_d;  // 1 when the data port owns the burst port.
    logic grant_d_next;
    logic other_pend;
    logic other_pend_next;
    logic done_q;
    logic d_req;
    logic resp_fire;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= idle;
            grant_d    <= 1'b0;
            other_pend <= 1'b0;
            done_q     <= 1'b0;
        end
        else
        begin
            state      <= state_next;
            grant_d    <= grant_d_next;
            other_pend <= other_pend_next;
            done_q     <= i_ser_done;  // write response goes out the cycle after the last beat.
        end
    end

    assign d_req     = i_dmem_read || i_dmem_write;
    assign resp_fire = ((state == read_wait) && i_line_valid) ||
                       ((state == write_wait) && done_q);

    always_comb
    begin
        state_next      = state;
        grant_d_next    = grant_d;
        other_pend_next = other_pend;
        unique case (state)
            idle:
            begin
                if (d_req)
                begin
                    grant_d_next    = 1'b1;  // data wins from idle.
                    other_pend_next = i_imem_read;
                    state_next      = i_dmem_write ? write_issue : read_issue;
                end
                else if (i_imem_read)
                begin
                    grant_d_next    = 1'b0;
                    other_pend_next = 1'b0;
                    state_next      = read_issue;
                end
            end
            read_issue:
            begin
                if (i_bmem_ready)
                    state_next = read_wait;
            end
            write_issue:
            begin
                if (i_bmem_ready)
                    state_next = write_wait;
            end
            read_wait, write_wait:
            begin
                if (resp_fire)
                begin
                    other_pend_next = 1'b0;
                    // only a data grant can leave the instruction side waiting.
                    if (other_pend)
                    begin
                        grant_d_next = 1'b0;
                        state_next   = read_issue;
                    end
                    else
                        state_next = idle;
                end
            end
            default: state_next = idle;
        endcase
    end

    // caches hold the address until their response, so no copy is kept here.
    assign o_bmem_addr = grant_d ? i_dmem_addr : i_imem_addr;
    assign o_bmem_read = (state == read_issue) && i_bmem_ready;

    assign o_ser_start = (state == write_issue) && i_bmem_ready;
    assign o_ser_line  = i_dmem_wdata;

    assign o_imem_resp  = resp_fire && !grant_d;
    assign o_dmem_resp  = resp_fire && grant_d;
    assign o_imem_rdata = i_line;
    assign o_dmem_rdata = i_line;

endmodule : cache_arbiter

// ==== line_assembler.sv ====
module line_assembler
    (
        input  logic                clk,
        input  logic                rst,

        input  mem_port_pkg::beat_t i_beat,
        input  logic                i_beat_valid,

        output mem_port_pkg::line_t o_line,
        output logic                o_line_valid
    );

    import mem_port_pkg::*;

    line_t     line_q;
    beat_idx_t cnt;
    logic      valid_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cnt     <= '0;
            valid_q <= 1'b0;
        end
        else
        begin
            // pulse once the last beat has been stored.
            valid_q <= i_beat_valid && (cnt == beat_idx_t'(LINE_BEATS - 1));
            if (i_beat_valid)
                cnt <= cnt + 1'b1;  // wraps back to beat 0 for the next line.
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_beat_valid)
            line_q[BEAT_W*cnt +: BEAT_W] <= i_beat;
    end

    assign o_line       = line_q;
    assign o_line_valid = valid_q;

endmodule : line_assembler

// ==== line_serializer.sv ====
module line_serializer
    (
        input  logic                clk,
        input  logic                rst,

        input  logic                i_start,
        input  mem_port_pkg::line_t i_line,

        output logic                o_busy,
        output mem_port_pkg::beat_t o_beat,
        output logic                o_beat_valid,
        output logic                o_done
    );

    import mem_port_pkg::*;

    line_t     line_q;
    beat_idx_t cnt;
    logic      busy;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            cnt  <= '0;
        end
        else if (busy)
        begin
            cnt <= cnt + 1'b1;
            if (cnt == beat_idx_t'(LINE_BEATS - 1))
                busy <= 1'b0;
        end
        else if (i_start)
        begin
            busy <= 1'b1;
            cnt  <= beat_idx_t'(1);  // beat 0 already left in the start cycle.
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_start && !busy)
            line_q <= i_line;
    end

    // the first beat comes straight from the input so it lines up with ready.
    assign o_beat       = busy ? line_q[BEAT_W*cnt +: BEAT_W] : i_line[BEAT_W-1:0];
    assign o_beat_valid = busy || i_start;
    assign o_done       = busy && (cnt == beat_idx_t'(LINE_BEATS - 1));
    assign o_busy       = busy;

endmodule : line_serializer

// ==== mem_port_pkg.sv ====
package mem_port_pkg;

    localparam int ADDR_W     = 32;
    localparam int BEAT_W     = 64;
    localparam int LINE_BEATS = 4;
    localparam int LINE_W     = BEAT_W * LINE_BEATS;

    // byte address, the caches keep it 32-byte aligned.
    typedef logic [ADDR_W-1:0] addr_t;

    // one beat on the burst memory data bus.
    typedef logic [BEAT_W-1:0] beat_t;

    typedef logic [LINE_W-1:0] line_t;  // beat 0 sits in the low 64 bits.

    typedef logic [$clog2(LINE_BEATS)-1:0] beat_idx_t;  // wraps after the last beat.

endpackage : mem_port_pkg

// ==== mem_port_top.sv ====
module mem_port_top
    (
        input  logic                clk,
        input  logic                rst,

        input  mem_port_pkg::addr_t i_imem_addr,
        input  logic                i_imem_read,
        output mem_port_pkg::line_t o_imem_rdata,
        output logic                o_imem_resp,

        input  mem_port_pkg::addr_t i_dmem_addr,
        input  logic                i_dmem_read,
        input  logic                i_dmem_write,
        input  mem_port_pkg::line_t i_dmem_wdata,
        output mem_port_pkg::line_t o_dmem_rdata,
        output logic                o_dmem_resp,

        output mem_port_pkg::addr_t o_bmem_addr,
        output logic                o_bmem_read,
        output logic                o_bmem_write,
        output mem_port_pkg::beat_t o_bmem_wdata,
        input  logic                i_bmem_ready,
        input  logic                i_bmem_rvalid,
        input  mem_port_pkg::beat_t i_bmem_rdata
    );

    import mem_port_pkg::*;

    logic  ser_start;
    line_t ser_line;
    logic  ser_done;
    line_t asm_line;
    logic  asm_line_valid;

    cache_arbiter arb0
    (
        .clk          (clk),
        .rst          (rst),
        .i_imem_addr  (i_imem_addr),
        .i_imem_read  (i_imem_read),
        .o_imem_rdata (o_imem_rdata),
        .o_imem_resp  (o_imem_resp),
        .i_dmem_addr  (i_dmem_addr),
        .i_dmem_read  (i_dmem_read),
        .i_dmem_write (i_dmem_write),
        .i_dmem_wdata (i_dmem_wdata),
        .o_dmem_rdata (o_dmem_rdata),
        .o_dmem_resp  (o_dmem_resp),
        .i_bmem_ready (i_bmem_ready),
        .o_bmem_addr  (o_bmem_addr),
        .o_bmem_read  (o_bmem_read),
        .o_ser_start  (ser_start),
        .o_ser_line   (ser_line),
        .i_ser_done   (ser_done),
        .i_line       (asm_line),
        .i_line_valid (asm_line_valid)
    );

    // write beats go straight out to the burst port.
    line_serializer ser0
    (
        .clk          (clk),
        .rst          (rst),
        .i_start      (ser_start),
        .i_line       (ser_line),
        .o_busy       (),
        .o_beat       (o_bmem_wdata),
        .o_beat_valid (o_bmem_write),
        .o_done       (ser_done)
    );

    line_assembler asm0
    (
        .clk          (clk),
        .rst          (rst),
        .i_beat       (i_bmem_rdata),
        .i_beat_valid (i_bmem_rvalid),
        .o_line       (asm_line),
        .o_line_valid (asm_line_valid)
    );

endmodule : mem_port_top

// ==== project.f ====
mem_port_pkg.sv
line_serializer.sv
line_assembler.sv
cache_arbiter.sv
mem_port_top.sv
tb_burst_mem.sv
tb_mem_port.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_mem_port -o sim_mem_port
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_mem_port > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== tb_burst_mem.sv ====
module tb_burst_mem
    (
        input  logic                clk,
        input  logic                rst,
        input  mem_port_pkg::addr_t i_addr,
        input  logic                i_read,
        input  logic                i_write,
        input  mem_port_pkg::beat_t i_wdata,
        output logic                o_ready,
        output logic                o_rvalid,
        output mem_port_pkg::beat_t o_rdata,
        output mem_port_pkg::line_t o_wline
    );

    import mem_port_pkg::*;

    beat_t     store [addr_t];  // written beats, keyed by beat byte address.
    logic      rst_q;
    logic      cmd_read;
    logic      cmd_write;
    addr_t     cmd_addr;
    beat_t     cmd_wdata;
    addr_t     rd_addr;
    beat_idx_t rd_beat;
    beat_idx_t wr_beat;
    logic      rd_busy;
    int        rd_wait;
    int        gap_left;
    logic      seeded = 1'b0;

    // unwritten memory follows the fill rule of the whole line address.
    function automatic beat_t read_beat(addr_t line_addr, beat_idx_t k);
        addr_t       key;
        logic [31:0] lo;
        key = line_addr + 32'(k) * 32'd8;
        lo  = line_addr ^ (32'(k) * 32'h01010101);
        if (store.exists(key))
            return store[key];
        return {~lo, lo};
    endfunction

    initial
    begin
        o_ready  = 1'b1;
        o_rvalid = 1'b0;
        o_rdata  = '0;
        o_wline  = '0;
    end

    // commands are taken as they stood just before the rising edge.
    always @(posedge clk)
    begin
        rst_q     <= rst;
        cmd_read  <= i_read;
        cmd_write <= i_write;
        cmd_addr  <= i_addr;
        cmd_wdata <= i_wdata;
    end

    always @(negedge clk)
    begin
        if (!seeded)
        begin
            void'($urandom(32'h160b));
            seeded = 1'b1;
        end
        o_rvalid = 1'b0;
        if (rst_q)
        begin
            o_ready  = 1'b1;
            rd_busy  = 1'b0;
            wr_beat  = '0;
            gap_left = 0;
        end
        else
        begin
            if (cmd_write)
            begin
                store[cmd_addr + 32'(wr_beat) * 32'd8] = cmd_wdata;
                o_wline[BEAT_W*wr_beat +: BEAT_W]     = cmd_wdata;
                wr_beat = wr_beat + 1'b1;
            end
            if (cmd_read)
            begin
                rd_addr = cmd_addr;
                rd_beat = '0;
                rd_wait = $urandom % 5 + 1;  // first beat lands 2 to 6 cycles after the command.
                rd_busy = 1'b1;
            end
            if (gap_left > 0)
            begin
                o_ready  = 1'b0;
                gap_left = gap_left - 1;
            end
            else
            begin
                o_ready  = 1'b1;
                gap_left = ($urandom % 3 == 0) ? $urandom % 4 : 0;
            end
            if (rd_busy)
            begin
                if (rd_wait > 0)
                    rd_wait = rd_wait - 1;
                else if ($urandom % 4 != 0)  // roughly one gap in four beat slots.
                begin
                    o_rvalid = 1'b1;
                    o_rdata  = read_beat(rd_addr, rd_beat);
                    if (rd_beat == beat_idx_t'(LINE_BEATS - 1))
                        rd_busy = 1'b0;
                    rd_beat = rd_beat + 1'b1;
                end
            end
        end
    end

endmodule : tb_burst_mem

// ==== tb_mem_port.sv ====
module tb_mem_port;

    import mem_port_pkg::*;

    localparam int NUM_TESTS = 8;
    localparam int PORT_I    = 1;
    localparam int PORT_D    = 2;

    localparam line_t WLINE_A = {64'h0123_4567_89ab_cdef, 64'h1122_3344_5566_7788,
                                 64'h8899_aabb_ccdd_eeff, 64'hfedc_ba98_7654_3210};
    localparam line_t WLINE_B = {64'h5a5a_0f0f_c3c3_9696, 64'h0000_ffff_1234_abcd,
                                 64'hdead_beef_cafe_f00d, 64'h7777_1111_4444_2222};

    logic  clk = 1'b0;
    logic  rst;
    addr_t imem_addr;
    logic  imem_read;
    line_t imem_rdata;
    logic  imem_resp;
    addr_t dmem_addr;
    logic  dmem_read;
    logic  dmem_write;
    line_t dmem_wdata;
    line_t dmem_rdata;
    logic  dmem_resp;
    addr_t bmem_addr;
    logic  bmem_read;
    logic  bmem_write;
    beat_t bmem_wdata;
    logic  bmem_ready;
    logic  bmem_rvalid;
    beat_t bmem_rdata;
    line_t mem_wline;

    string t_name [NUM_TESTS];
    int    t_ports [NUM_TESTS];
    logic  t_write [NUM_TESTS];
    addr_t t_iaddr [NUM_TESTS];
    addr_t t_daddr [NUM_TESTS];
    line_t t_wline [NUM_TESTS];

    line_t shadow [addr_t];  // lines written so far, by line address.
    addr_t cmd_addrs [$];    // address of every read or write command, in order.
    int    i_resps;
    int    d_resps;
    line_t i_line_got;
    line_t d_line_got;
    logic  write_q = 1'b0;
    int    value_errs;
    int    other_errs;
    int    proto_errs;

    mem_port_top dut0
    (
        .clk          (clk),
        .rst          (rst),
        .i_imem_addr  (imem_addr),
        .i_imem_read  (imem_read),
        .o_imem_rdata (imem_rdata),
        .o_imem_resp  (imem_resp),
        .i_dmem_addr  (dmem_addr),
        .i_dmem_read  (dmem_read),
        .i_dmem_write (dmem_write),
        .i_dmem_wdata (dmem_wdata),
        .o_dmem_rdata (dmem_rdata),
        .o_dmem_resp  (dmem_resp),
        .o_bmem_addr  (bmem_addr),
        .o_bmem_read  (bmem_read),
        .o_bmem_write (bmem_write),
        .o_bmem_wdata (bmem_wdata),
        .i_bmem_ready (bmem_ready),
        .i_bmem_rvalid(bmem_rvalid),
        .i_bmem_rdata (bmem_rdata)
    );

    tb_burst_mem mem0
    (
        .clk      (clk),
        .rst      (rst),
        .i_addr   (bmem_addr),
        .i_read   (bmem_read),
        .i_write  (bmem_write),
        .i_wdata  (bmem_wdata),
        .o_ready  (bmem_ready),
        .o_rvalid (bmem_rvalid),
        .o_rdata  (bmem_rdata),
        .o_wline  (mem_wline)
    );

    task automatic set_entry(int idx, string name, int ports, logic wr, addr_t ia, addr_t da,
                             line_t wl);
        t_name[idx]  = name;
        t_ports[idx] = ports;
        t_write[idx] = wr;
        t_iaddr[idx] = ia;
        t_daddr[idx] = da;
        t_wline[idx] = wl;
    endtask

    // beat k of line A reads A ^ (k * 0x01010101), upper half inverted.
    function automatic line_t expected_line(addr_t a);
        line_t       l;
        logic [31:0] lo;
        if (shadow.exists(a))
            return shadow[a];
        for (int k = 0; k < LINE_BEATS; k++)
        begin
            lo = a ^ (k * 32'h01010101);
            l[BEAT_W*k +: BEAT_W] = {~lo, lo};
        end
        return l;
    endfunction

    task automatic check_line(string name, line_t exp, line_t act);
        if (act !== exp)
        begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_addr(string name, addr_t exp, addr_t act);
        if (act !== exp)
        begin
            $display("Fail %s: expected address %h, actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_idle_outputs(string when);
        if (bmem_read !== 1'b0 || bmem_write !== 1'b0 ||
            imem_resp !== 1'b0 || dmem_resp !== 1'b0)
        begin
            $display("Error: a command or response strobe was not low %s", when);
            other_errs++;
        end
    endtask

    initial
    begin
        forever #5 clk = ~clk;
    end

    // sampled before the edge updates the DUT, so these are the values it acted on.
    always @(posedge clk)
    begin
        if (imem_resp)
        begin
            i_resps++;
            i_line_got = imem_rdata;
        end
        if (dmem_resp)
        begin
            d_resps++;
            d_line_got = dmem_rdata;
        end
        if (bmem_read || (bmem_write && !write_q))
        begin
            if (!bmem_ready)
            begin
                $display("Error: burst command issued while ready was low at %0t", $time);
                proto_errs++;
            end
            cmd_addrs.push_back(bmem_addr);
        end
        write_q = bmem_write;
    end

    initial
    begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        $display("Error: watchdog expired before the test table finished");
        $display("** FAIL **");
        $finish;
    end

    initial
    begin
        int    i_base;
        int    d_base;
        int    c_base;
        int    n_i;
        int    n_d;
        int    wait_cyc;
        line_t i_exp;
        line_t d_exp;
        set_entry(0, "i_read",      PORT_I,          1'b0, 32'h0000_1000, 32'h0,         '0);
        set_entry(1, "d_read",      PORT_D,          1'b0, 32'h0,         32'h0000_2040, '0);
        set_entry(2, "d_write",     PORT_D,          1'b1, 32'h0,         32'h0000_3000, WLINE_A);
        set_entry(3, "d_readback",  PORT_D,          1'b0, 32'h0,         32'h0000_3000, '0);
        set_entry(4, "both_read",   PORT_I | PORT_D, 1'b0, 32'h0000_5000, 32'h0000_4020, '0);
        set_entry(5, "both_write",  PORT_I | PORT_D, 1'b1, 32'h0000_3000, 32'h0000_6000, WLINE_B);
        set_entry(6, "i_readback",  PORT_I,          1'b0, 32'h0000_6000, 32'h0,         '0);
        set_entry(7, "d_high_addr", PORT_D,          1'b0, 32'h0,         32'hffff_ffe0, '0);
        rst        = 1'b1;
        imem_addr  = '0;
        imem_read  = 1'b0;
        dmem_addr  = '0;
        dmem_read  = 1'b0;
        dmem_write = 1'b0;
        dmem_wdata = '0;
        repeat (16)
        begin
            @(negedge clk);
            check_idle_outputs("during reset");
        end
        rst = 1'b0;
        @(negedge clk);
        check_idle_outputs("right after reset");

        for (int t = 0; t < NUM_TESTS; t++)
        begin
            i_base     = i_resps;
            d_base     = d_resps;
            c_base     = cmd_addrs.size();
            n_i        = (t_ports[t] & PORT_I) != 0 ? 1 : 0;
            n_d        = (t_ports[t] & PORT_D) != 0 ? 1 : 0;
            i_exp      = expected_line(t_iaddr[t]);
            d_exp      = expected_line(t_daddr[t]);
            imem_addr  = t_iaddr[t];
            imem_read  = (n_i != 0);
            dmem_addr  = t_daddr[t];
            dmem_read  = (n_d != 0) && !t_write[t];
            dmem_write = (n_d != 0) && t_write[t];
            dmem_wdata = t_wline[t];
            wait_cyc   = 0;
            while ((imem_read || dmem_read || dmem_write) && wait_cyc < 150)
            begin
                @(negedge clk);
                wait_cyc++;
                if (i_resps != i_base)
                    imem_read = 1'b0;  // a cache drops its request after the response.
                if (d_resps != d_base)
                begin
                    dmem_read  = 1'b0;
                    dmem_write = 1'b0;
                end
            end
            repeat (3) @(negedge clk);
            if (i_resps - i_base != n_i || d_resps - d_base != n_d)
            begin
                $write("Error: test %s expected %0d instruction and %0d data responses, ",
                       t_name[t], n_i, n_d);
                $display("saw %0d and %0d", i_resps - i_base, d_resps - d_base);
                other_errs++;
                imem_read  = 1'b0;
                dmem_read  = 1'b0;
                dmem_write = 1'b0;
            end
            else
            begin
                if (n_i != 0)
                    check_line(t_name[t], i_exp, i_line_got);
                if (n_d != 0 && !t_write[t])
                    check_line(t_name[t], d_exp, d_line_got);
                if (n_d != 0 && t_write[t])
                begin
                    check_line(t_name[t], t_wline[t], mem_wline);
                    shadow[t_daddr[t]] = t_wline[t];
                end
                if (n_i != 0 && n_d != 0)
                begin
                    if (cmd_addrs.size() - c_base < 2)
                    begin
                        $display("Error: test %s issued fewer than two burst commands", t_name[t]);
                        other_errs++;
                    end
                    else
                    begin
                        check_addr(t_name[t], t_daddr[t], cmd_addrs[c_base]);
                        check_addr(t_name[t], t_iaddr[t], cmd_addrs[c_base + 1]);
                    end
                end
            end
        end

        $display("value errors: %0d, response errors: %0d, protocol errors: %0d",
                 value_errs, other_errs, proto_errs);
        if (value_errs + other_errs + proto_errs == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule : tb_mem_port
